// ==== vlog.f ====
+incdir+dv
src/mem_stats_pkg.sv
src/dm_cmd_tracker.sv
src/stream_stats.sv
src/stats_regs.sv
src/mem_stats_top.sv
dv/mem_stats_tb.sv

// ==== dv/mem_stats_checks.svh ====
// Typed compare tasks, included inside mem_stats_tb after the package import; end_with_failure lives there
`ifndef MEM_STATS_CHECKS_SVH
`define MEM_STATS_CHECKS_SVH

// Packed mover command word
task automatic check_cmd(input string name, input dm_cmd_t exp, input dm_cmd_t act);
   if (act !== exp) begin
      $display("ERR t=%0t %s exp=0x%018h act=0x%018h", $time, name, exp, act);
      end_with_failure();
   end
endtask

// Counter value as read through the register port
task automatic check_count(input string name, input reg_data_t exp, input reg_data_t act);
   if (act !== exp) begin
      $display("ERR t=%0t %s exp=%0d act=%0d", $time, name, exp, act);
      end_with_failure();
   end
endtask

// Single control bit, valid or ready
task automatic check_bit(input string name, input logic exp, input logic act);
   if (act !== exp) begin
      $display("ERR t=%0t %s exp=%b act=%b", $time, name, exp, act);
      end_with_failure();
   end
endtask

`endif

// ==== dv/mem_stats_tb.sv ====
// Directed tests at DATA_BYTES 64; drives on rising edges, samples on falling edges, stops at first error
module mem_stats_tb;

   import mem_stats_pkg::*;

   localparam int DATA_BYTES     = 64;
   localparam int SEED           = 62;
   localparam int TIMEOUT_CYCLES = 2000;  // Tests need roughly 500 cycles
   localparam int RD_WAIT_MAX    = 8;     // Cycles allowed for a read answer

   logic                  mem_clk;
   logic                  mem_aresetn;
   logic                  wr_cmd_valid, wr_cmd_ready, wr_dm_cmd_valid, wr_dm_cmd_ready;
   addr_t                 wr_cmd_addr;
   btt_t                  wr_cmd_len;
   dm_cmd_t               wr_dm_cmd_data;
   logic                  wr_sts_valid, wr_sts_ready;
   sts_t                  wr_sts_data;
   logic                  wr_data_valid, wr_data_ready, wr_data_last;
   logic [DATA_BYTES-1:0] wr_data_keep;
   logic                  rd_cmd_valid, rd_cmd_ready, rd_dm_cmd_valid, rd_dm_cmd_ready;
   addr_t                 rd_cmd_addr;
   btt_t                  rd_cmd_len;
   dm_cmd_t               rd_dm_cmd_data;
   logic                  rd_sts_valid, rd_sts_ready;
   sts_t                  rd_sts_data;
   logic                  rd_data_valid, rd_data_ready, rd_data_last;
   logic [DATA_BYTES-1:0] rd_data_keep;
   logic                  reg_rd_en, reg_rd_valid;
   reg_addr_t             reg_addr;
   reg_data_t             reg_rd_data;

   reg_data_t exp_reg [16];  // Model of every slot, 12..15 stay zero
   int        cycle_count;
   int        rd_wait;       // Extra cycles the last read waited

   task automatic end_with_failure();
      $display("Finished with errors");
      $fatal(1, "run stopped at first failure");
   endtask

   `include "mem_stats_checks.svh"

   mem_stats_top #(.DATA_BYTES(DATA_BYTES)) mem_stats_top_inst (.*);

   always #2 mem_clk = ~mem_clk;  // Period 4

   always @(posedge mem_clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: tests did not complete within %0d cycles", TIMEOUT_CYCLES);
         end_with_failure();
      end
   end

   // Command word as the mover expects it, field by field
   function automatic dm_cmd_t expected_cmd(input addr_t a, input btt_t len);
      return {8'h00, a, 1'b1, 1'b1, 6'h00, 1'b1, len};  // Rsvd+tag, addr, drr, eof, dsa, type
   endfunction

   // Low ones for the given number of 8-byte groups
   function automatic logic [DATA_BYTES-1:0] keep_of(input int groups);
      logic [DATA_BYTES-1:0] k;
      k = '0;
      for (int i = 0; i < 8 * groups; i++) begin
         k[i] = 1'b1;
      end
      return k;
   endfunction

   // Strobe one read, then wait for the answer
   task automatic read_reg(input reg_addr_t a, output reg_data_t d);
      rd_wait = 0;
      @(posedge mem_clk);
      reg_rd_en <= 1'b1;
      reg_addr  <= a;
      @(posedge mem_clk);  // Strobe taken here
      reg_rd_en <= 1'b0;
      @(negedge mem_clk);
      while (reg_rd_valid !== 1'b1) begin
         rd_wait++;
         if (rd_wait > RD_WAIT_MAX) begin
            $display("Register read of slot %0d never raised reg_rd_valid", a);
            end_with_failure();
         end
         @(negedge mem_clk);
      end
      d = reg_rd_data;
   endtask

   task automatic check_all_regs();
      reg_data_t d;
      for (int a = 0; a < 12; a++) begin
         read_reg(reg_addr_t'(a), d);
         check_count($sformatf("reg[%0d]", a), exp_reg[a], d);
      end
   endtask

   task automatic reset_state_reads();
      reg_data_t d;
      repeat (3) begin
         @(negedge mem_clk);
         check_bit("reg_rd_valid", 1'b0, reg_rd_valid);  // Nothing asked yet
      end
      for (int a = 0; a < 12; a++) begin
         read_reg(reg_addr_t'(a), d);
         check_count($sformatf("reg[%0d]", a), 64'd0, d);
         check_bit("reg_rd_valid one cycle after strobe", 1'b1, rd_wait == 0);
         @(negedge mem_clk);
         check_bit("reg_rd_valid", 1'b0, reg_rd_valid);  // Single-cycle pulse
      end
   endtask

   task automatic command_packing();
      addr_t wa, ra;
      btt_t  wl, rl;
      logic  wv, wr, rv, rr;
      for (int i = 0; i < 40; i++) begin
         wa = $urandom;
         wl = btt_t'($urandom);
         wv = ($urandom % 4) != 0;
         wr = $urandom % 2;  // Mover stalls about half the time
         ra = $urandom;
         rl = btt_t'($urandom);
         rv = ($urandom % 4) != 0;
         rr = $urandom % 2;
         @(posedge mem_clk);
         wr_cmd_valid    <= wv;
         wr_cmd_addr     <= wa;
         wr_cmd_len      <= wl;
         wr_dm_cmd_ready <= wr;
         rd_cmd_valid    <= rv;
         rd_cmd_addr     <= ra;
         rd_cmd_len      <= rl;
         rd_dm_cmd_ready <= rr;
         @(negedge mem_clk);
         check_cmd("wr_dm_cmd_data", expected_cmd(wa, wl), wr_dm_cmd_data);
         check_bit("wr_cmd_ready", wr, wr_cmd_ready);
         check_bit("wr_dm_cmd_valid", wv, wr_dm_cmd_valid);
         check_cmd("rd_dm_cmd_data", expected_cmd(ra, rl), rd_dm_cmd_data);
         check_bit("rd_cmd_ready", rr, rd_cmd_ready);
         check_bit("rd_dm_cmd_valid", rv, rd_dm_cmd_valid);
         if (wv && wr) exp_reg[REG_WR_CMD] += 1;  // Taken at the coming edge
         if (rv && rr) exp_reg[REG_RD_CMD] += 1;
      end
      @(posedge mem_clk);
      wr_cmd_valid    <= 1'b0;
      wr_dm_cmd_ready <= 1'b0;
      rd_cmd_valid    <= 1'b0;
      rd_dm_cmd_ready <= 1'b0;
      check_all_regs();
   endtask

   task automatic status_counting();
      logic wv, wr, rv, rr;
      sts_t ws, rs;
      for (int i = 0; i < 30; i++) begin
         wv = $urandom % 2;
         wr = ($urandom % 4) != 0;
         ws = sts_t'($urandom);  // Bit 7 random, so good and bad mix
         rv = $urandom % 2;
         rr = ($urandom % 4) != 0;
         rs = sts_t'($urandom);
         @(posedge mem_clk);
         wr_sts_valid <= wv;
         wr_sts_ready <= wr;
         wr_sts_data  <= ws;
         rd_sts_valid <= rv;
         rd_sts_ready <= rr;
         rd_sts_data  <= rs;
         if (wv && wr) begin
            exp_reg[REG_WR_STS] += 1;
            if (!ws[7]) exp_reg[REG_WR_STS_ERR] += 1;  // Okay bit clear
         end
         if (rv && rr) begin
            exp_reg[REG_RD_STS] += 1;
            if (!rs[7]) exp_reg[REG_RD_STS_ERR] += 1;
         end
      end
      @(posedge mem_clk);
      wr_sts_valid <= 1'b0;
      wr_sts_ready <= 1'b0;
      rd_sts_valid <= 1'b0;
      rd_sts_ready <= 1'b0;
      check_all_regs();
   endtask

   // One beat, held until the random ready lets it through
   task automatic send_beat(input bit rd_dir, input logic [DATA_BYTES-1:0] keep,
                            input logic last);
      logic rdy;
      int   bytes;
      bytes = 0;
      for (int i = 0; i < DATA_BYTES; i++) begin
         bytes += keep[i];
      end
      do begin
         rdy = ($urandom % 4) != 0;
         @(posedge mem_clk);
         if (rd_dir) begin
            rd_data_valid <= 1'b1;
            rd_data_ready <= rdy;
            rd_data_keep  <= keep;
            rd_data_last  <= last;
         end else begin
            wr_data_valid <= 1'b1;
            wr_data_ready <= rdy;
            wr_data_keep  <= keep;
            wr_data_last  <= last;
         end
      end while (!rdy);
      if (rd_dir) begin
         exp_reg[REG_RD_WORDS] += 1;
         exp_reg[REG_RD_BYTES] += bytes;
         if (last) exp_reg[REG_RD_PKTS] += 1;
      end else begin
         exp_reg[REG_WR_WORDS] += 1;
         exp_reg[REG_WR_BYTES] += bytes;
         if (last) exp_reg[REG_WR_PKTS] += 1;
      end
   endtask

   task automatic packet_counting();
      int beats;
      int groups;
      for (int dir = 0; dir < 2; dir++) begin
         for (int p = 0; p < 4; p++) begin
            beats  = 1 + $urandom % 6;
            groups = 1 + $urandom % (DATA_BYTES / 8);  // Partial last beat
            for (int b = 0; b < beats; b++) begin
               send_beat(dir[0], (b == beats - 1) ? keep_of(groups) : '1, b == beats - 1);
            end
         end
         @(posedge mem_clk);  // Last beat of this direction taken here
         wr_data_valid <= 1'b0;
         wr_data_ready <= 1'b0;
         rd_data_valid <= 1'b0;
         rd_data_ready <= 1'b0;
      end
      check_all_regs();
   endtask

   task automatic read_port_sweep();
      reg_addr_t seq [8];
      reg_data_t d;
      seq = '{REG_WR_BYTES, 4'd13, REG_RD_CMD, REG_RD_BYTES, REG_WR_STS, 4'd15, REG_RD_PKTS,
              REG_WR_WORDS};
      for (int a = 12; a < 16; a++) begin
         read_reg(reg_addr_t'(a), d);
         check_count($sformatf("reg[%0d]", a), 64'd0, d);  // Unmapped slot
      end
      // Strobe every cycle; each answer lands one cycle behind its strobe
      for (int i = 0; i <= 8; i++) begin
         @(posedge mem_clk);
         reg_rd_en <= (i < 8);
         reg_addr  <= (i < 8) ? seq[i] : '0;
         @(negedge mem_clk);
         if (i > 0) begin
            check_bit("reg_rd_valid", 1'b1, reg_rd_valid);
            check_count($sformatf("reg[%0d] back to back", seq[i-1]), exp_reg[seq[i-1]],
                        reg_rd_data);
         end
      end
      @(negedge mem_clk);
      check_bit("reg_rd_valid", 1'b0, reg_rd_valid);
   endtask

   initial begin
      void'($urandom(SEED));
      mem_clk         = 1'b0;
      mem_aresetn     = 1'b0;
      cycle_count     = 0;
      wr_cmd_valid    = 1'b0;
      wr_cmd_addr     = '0;
      wr_cmd_len      = '0;
      wr_dm_cmd_ready = 1'b0;
      wr_sts_valid    = 1'b0;
      wr_sts_ready    = 1'b0;
      wr_sts_data     = '0;
      wr_data_valid   = 1'b0;
      wr_data_ready   = 1'b0;
      wr_data_keep    = '0;
      wr_data_last    = 1'b0;
      rd_cmd_valid    = 1'b0;
      rd_cmd_addr     = '0;
      rd_cmd_len      = '0;
      rd_dm_cmd_ready = 1'b0;
      rd_sts_valid    = 1'b0;
      rd_sts_ready    = 1'b0;
      rd_sts_data     = '0;
      rd_data_valid   = 1'b0;
      rd_data_ready   = 1'b0;
      rd_data_keep    = '0;
      rd_data_last    = 1'b0;
      reg_rd_en       = 1'b0;
      reg_addr        = '0;
      foreach (exp_reg[i]) exp_reg[i] = '0;
      repeat (8) @(posedge mem_clk);
      mem_aresetn <= 1'b1;
      reset_state_reads();
      command_packing();
      status_counting();
      packet_counting();
      read_port_sweep();
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== src/mem_stats_top.sv ====
// Memory command and statistics top, single mem_clk domain; data buses are not carried, only observed
module mem_stats_top #(
   parameter int DATA_BYTES = 64  // Stream width in bytes, multiple of 8
) (
   input  logic                     mem_clk,
   input  logic                     mem_aresetn,

   // Write command, user and mover sides
   input  logic                     wr_cmd_valid,
   input  mem_stats_pkg::addr_t     wr_cmd_addr,
   input  mem_stats_pkg::btt_t      wr_cmd_len,
   output logic                     wr_cmd_ready,
   output logic                     wr_dm_cmd_valid,
   input  logic                     wr_dm_cmd_ready,
   output mem_stats_pkg::dm_cmd_t   wr_dm_cmd_data,

   // Write status and data, observed
   input  logic                     wr_sts_valid,
   input  logic                     wr_sts_ready,
   input  mem_stats_pkg::sts_t      wr_sts_data,
   input  logic                     wr_data_valid,
   input  logic                     wr_data_ready,
   input  logic [DATA_BYTES-1:0]    wr_data_keep,
   input  logic                     wr_data_last,

   // Read command, user and mover sides
   input  logic                     rd_cmd_valid,
   input  mem_stats_pkg::addr_t     rd_cmd_addr,
   input  mem_stats_pkg::btt_t      rd_cmd_len,
   output logic                     rd_cmd_ready,
   output logic                     rd_dm_cmd_valid,
   input  logic                     rd_dm_cmd_ready,
   output mem_stats_pkg::dm_cmd_t   rd_dm_cmd_data,

   // Read status and data, observed
   input  logic                     rd_sts_valid,
   input  logic                     rd_sts_ready,
   input  mem_stats_pkg::sts_t      rd_sts_data,
   input  logic                     rd_data_valid,
   input  logic                     rd_data_ready,
   input  logic [DATA_BYTES-1:0]    rd_data_keep,
   input  logic                     rd_data_last,

   // Statistics read port
   input  logic                     reg_rd_en,
   input  mem_stats_pkg::reg_addr_t reg_addr,
   output logic                     reg_rd_valid,
   output mem_stats_pkg::reg_data_t reg_rd_data
);

   import mem_stats_pkg::*;

   // Write side counters
   count_t      wr_cmd_count;
   count_t      wr_sts_count;
   count_t      wr_sts_err_count;
   count_t      wr_word_count;
   count_t      wr_pkt_count;
   byte_count_t wr_byte_count;

   // Read side counters
   count_t      rd_cmd_count;
   count_t      rd_sts_count;
   count_t      rd_sts_err_count;
   count_t      rd_word_count;
   count_t      rd_pkt_count;
   byte_count_t rd_byte_count;

   // Write command path, s2mm side of the mover
   dm_cmd_tracker wr_cmd_inst (
      .mem_clk       (mem_clk),
      .mem_aresetn   (mem_aresetn),
      .cmd_valid     (wr_cmd_valid),
      .cmd_addr      (wr_cmd_addr),
      .cmd_len       (wr_cmd_len),
      .cmd_ready     (wr_cmd_ready),
      .dm_cmd_valid  (wr_dm_cmd_valid),
      .dm_cmd_ready  (wr_dm_cmd_ready),
      .dm_cmd_data   (wr_dm_cmd_data),
      .sts_valid     (wr_sts_valid),
      .sts_ready     (wr_sts_ready),
      .sts_data      (wr_sts_data),
      .cmd_count     (wr_cmd_count),
      .sts_count     (wr_sts_count),
      .sts_err_count (wr_sts_err_count)
   );

   // Read command path, mm2s side of the mover
   dm_cmd_tracker rd_cmd_inst (
      .mem_clk       (mem_clk),
      .mem_aresetn   (mem_aresetn),
      .cmd_valid     (rd_cmd_valid),
      .cmd_addr      (rd_cmd_addr),
      .cmd_len       (rd_cmd_len),
      .cmd_ready     (rd_cmd_ready),
      .dm_cmd_valid  (rd_dm_cmd_valid),
      .dm_cmd_ready  (rd_dm_cmd_ready),
      .dm_cmd_data   (rd_dm_cmd_data),
      .sts_valid     (rd_sts_valid),
      .sts_ready     (rd_sts_ready),
      .sts_data      (rd_sts_data),
      .cmd_count     (rd_cmd_count),
      .sts_count     (rd_sts_count),
      .sts_err_count (rd_sts_err_count)
   );

   // Write data into the mover
   stream_stats #(.DATA_BYTES(DATA_BYTES)) wr_stream_inst (
      .mem_clk     (mem_clk),
      .mem_aresetn (mem_aresetn),
      .data_valid  (wr_data_valid),
      .data_ready  (wr_data_ready),
      .data_last   (wr_data_last),
      .data_keep   (wr_data_keep),
      .word_count  (wr_word_count),
      .pkt_count   (wr_pkt_count),
      .byte_count  (wr_byte_count)
   );

   // Read data out of the mover
   stream_stats #(.DATA_BYTES(DATA_BYTES)) rd_stream_inst (
      .mem_clk     (mem_clk),
      .mem_aresetn (mem_aresetn),
      .data_valid  (rd_data_valid),
      .data_ready  (rd_data_ready),
      .data_last   (rd_data_last),
      .data_keep   (rd_data_keep),
      .word_count  (rd_word_count),
      .pkt_count   (rd_pkt_count),
      .byte_count  (rd_byte_count)
   );

   // Software view of all twelve counters
   stats_regs stats_regs_inst (
      .mem_clk          (mem_clk),
      .mem_aresetn      (mem_aresetn),
      .reg_rd_en        (reg_rd_en),
      .reg_addr         (reg_addr),
      .reg_rd_valid     (reg_rd_valid),
      .reg_rd_data      (reg_rd_data),
      .wr_cmd_count     (wr_cmd_count),
      .wr_sts_count     (wr_sts_count),
      .wr_sts_err_count (wr_sts_err_count),
      .wr_word_count    (wr_word_count),
      .wr_pkt_count     (wr_pkt_count),
      .wr_byte_count    (wr_byte_count),
      .rd_cmd_count     (rd_cmd_count),
      .rd_sts_count     (rd_sts_count),
      .rd_sts_err_count (rd_sts_err_count),
      .rd_word_count    (rd_word_count),
      .rd_pkt_count     (rd_pkt_count),
      .rd_byte_count    (rd_byte_count)
   );

endmodule

// ==== src/stats_regs.sv ====
// Strobe read port over the twelve counters; one-cycle latency, a new read may start every cycle
module stats_regs (
   input  logic                       mem_clk,
   input  logic                       mem_aresetn,

   // Read strobe port
   input  logic                       reg_rd_en,
   input  mem_stats_pkg::reg_addr_t   reg_addr,
   output logic                       reg_rd_valid,
   output mem_stats_pkg::reg_data_t   reg_rd_data,

   // Write direction counters
   input  mem_stats_pkg::count_t      wr_cmd_count,
   input  mem_stats_pkg::count_t      wr_sts_count,
   input  mem_stats_pkg::count_t      wr_sts_err_count,
   input  mem_stats_pkg::count_t      wr_word_count,
   input  mem_stats_pkg::count_t      wr_pkt_count,
   input  mem_stats_pkg::byte_count_t wr_byte_count,

   // Read direction counters
   input  mem_stats_pkg::count_t      rd_cmd_count,
   input  mem_stats_pkg::count_t      rd_sts_count,
   input  mem_stats_pkg::count_t      rd_sts_err_count,
   input  mem_stats_pkg::count_t      rd_word_count,
   input  mem_stats_pkg::count_t      rd_pkt_count,
   input  mem_stats_pkg::byte_count_t rd_byte_count
);

   import mem_stats_pkg::*;

   reg_data_t rd_mux;  // Selected counter, zero-extended

   // Address decode
   always_comb begin
      case (reg_addr)
         REG_WR_CMD:     rd_mux = reg_data_t'(wr_cmd_count);
         REG_WR_STS:     rd_mux = reg_data_t'(wr_sts_count);
         REG_WR_STS_ERR: rd_mux = reg_data_t'(wr_sts_err_count);
         REG_WR_WORDS:   rd_mux = reg_data_t'(wr_word_count);
         REG_WR_PKTS:    rd_mux = reg_data_t'(wr_pkt_count);
         REG_WR_BYTES:   rd_mux = reg_data_t'(wr_byte_count);
         REG_RD_CMD:     rd_mux = reg_data_t'(rd_cmd_count);
         REG_RD_STS:     rd_mux = reg_data_t'(rd_sts_count);
         REG_RD_STS_ERR: rd_mux = reg_data_t'(rd_sts_err_count);
         REG_RD_WORDS:   rd_mux = reg_data_t'(rd_word_count);
         REG_RD_PKTS:    rd_mux = reg_data_t'(rd_pkt_count);
         REG_RD_BYTES:   rd_mux = reg_data_t'(rd_byte_count);
         default:        rd_mux = '0;  // Unmapped slots
      endcase
   end

   // Valid pulse, follows the strobe by one cycle
   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         reg_rd_valid <= 1'b0;
      end else begin
         reg_rd_valid <= reg_rd_en;
      end
   end

   // Capture the counter seen in the strobe cycle
   always_ff @(posedge mem_clk) begin
      if (reg_rd_en) begin
         reg_rd_data <= rd_mux;  // Held until the next strobe
      end
   end

   // Every strobe answers next cycle and nothing else raises valid
   a_rd_latency : assert property (
      @(posedge mem_clk) disable iff (!mem_aresetn)
      1'b1 |=> (reg_rd_valid == $past(reg_rd_en))
   ) else $error("reg_rd_valid does not follow reg_rd_en by one cycle");

endmodule

// ==== src/stream_stats.sv ====
// Counts beats, packets and bytes of one stream; keep must be contiguous low ones in 8-byte steps
module stream_stats #(
   parameter int DATA_BYTES = 64  // Stream width in bytes, multiple of 8
) (
   input  logic                       mem_clk,
   input  logic                       mem_aresetn,

   // Observed handshake and framing
   input  logic                       data_valid,
   input  logic                       data_ready,
   input  logic                       data_last,
   input  logic [DATA_BYTES-1:0]      data_keep,

   // Statistics
   output mem_stats_pkg::count_t      word_count,
   output mem_stats_pkg::count_t      pkt_count,
   output mem_stats_pkg::byte_count_t byte_count
);

   import mem_stats_pkg::*;

   localparam int KEEP_GRAIN = 8;                        // Bytes per keep step
   localparam int GROUPS     = DATA_BYTES / KEEP_GRAIN;  // Legal keep patterns
   localparam int BEAT_W     = $clog2(DATA_BYTES + 1);   // Holds 0..DATA_BYTES

   logic                  beat_fire;   // Beat accepted this cycle
   logic [BEAT_W-1:0]     beat_bytes;  // Bytes the keep mask stands for
   logic                  keep_ok;     // Keep matched a legal pattern
   logic [DATA_BYTES-1:0] keep_mask;   // Candidate pattern in the search

   assign beat_fire = data_valid & data_ready;

   // Match keep against each contiguous 8-byte-multiple pattern
   always_comb begin
      beat_bytes = '0;
      keep_ok    = 1'b0;
      keep_mask  = '0;
      for (int g = 1; g <= GROUPS; g++) begin
         keep_mask = {DATA_BYTES{1'b1}} >> (DATA_BYTES - KEEP_GRAIN * g);
         if (data_keep == keep_mask) begin
            beat_bytes = BEAT_W'(KEEP_GRAIN * g);  // Low g groups valid
            keep_ok    = 1'b1;
         end
      end
   end

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         word_count <= '0;
         pkt_count  <= '0;
         byte_count <= '0;
      end else if (beat_fire) begin
         word_count <= word_count + 1'b1;                      // Every beat
         byte_count <= byte_count + byte_count_t'(beat_bytes);  // Zero if keep odd
         if (data_last) begin
            pkt_count <= pkt_count + 1'b1;  // Frame closed
         end
      end
   end

   // An odd keep pattern on a taken beat is lost from the byte total
   a_keep_legal : assert property (
      @(posedge mem_clk) disable iff (!mem_aresetn)
      beat_fire |-> keep_ok
   ) else $error("keep 0x%0h is not a contiguous multiple of 8 bytes", data_keep);

endmodule

// ==== src/dm_cmd_tracker.sv ====
// Packs one direction's mover command and counts commands and statuses; valid/ready pass through
module dm_cmd_tracker (
   input  logic                   mem_clk,
   input  logic                   mem_aresetn,

   // User command side
   input  logic                   cmd_valid,
   input  mem_stats_pkg::addr_t   cmd_addr,
   input  mem_stats_pkg::btt_t    cmd_len,
   output logic                   cmd_ready,

   // Mover command side
   output logic                   dm_cmd_valid,
   input  logic                   dm_cmd_ready,
   output mem_stats_pkg::dm_cmd_t dm_cmd_data,

   // Status stream, observed only
   input  logic                   sts_valid,
   input  logic                   sts_ready,
   input  mem_stats_pkg::sts_t    sts_data,

   // Statistics
   output mem_stats_pkg::count_t  cmd_count,
   output mem_stats_pkg::count_t  sts_count,
   output mem_stats_pkg::count_t  sts_err_count
);

   import mem_stats_pkg::*;

   logic cmd_fire;  // Command accepted by mover
   logic sts_fire;  // Status taken by user
   logic sts_err;   // Taken status reports failure

   // Handshake passes straight through, no buffering
   assign dm_cmd_valid = cmd_valid;
   assign cmd_ready    = dm_cmd_ready;

   // Mover command word layout
   //   [71:68] reserved  [67:64] tag  [63:32] address
   //   [31] drr  [30] eof  [29:24] dsa  [23] type  [22:0] btt
   assign dm_cmd_data = {4'h0,       // Reserved
                         4'h0,       // Tag 0
                         cmd_addr,   // Start address
                         1'b1,       // Drr, realign at start
                         1'b1,       // Eof, single command per frame
                         6'h00,      // Dsa unused
                         1'b1,       // Type, incrementing burst
                         cmd_len};   // Bytes to transfer

   assign cmd_fire = cmd_valid & dm_cmd_ready;
   assign sts_fire = sts_valid & sts_ready;
   assign sts_err  = sts_fire & ~sts_data[STS_OKAY_BIT];

   always_ff @(posedge mem_clk) begin
      if (!mem_aresetn) begin
         cmd_count     <= '0;
         sts_count     <= '0;
         sts_err_count <= '0;
      end else begin
         if (cmd_fire) begin
            cmd_count <= cmd_count + 1'b1;  // One per accepted command
         end
         if (sts_fire) begin
            sts_count <= sts_count + 1'b1;  // Every status, good or bad
         end
         if (sts_err) begin
            sts_err_count <= sts_err_count + 1'b1;  // Okay bit clear
         end
      end
   end

   // Error count is a subset of the status count over the whole run
   a_err_within_sts : assert property (
      @(posedge mem_clk) disable iff (!mem_aresetn)
      sts_err_count <= sts_count
   ) else $error("sts_err_count %0d above sts_count %0d", sts_err_count, sts_count);

endmodule

// ==== src/mem_stats_pkg.sv ====
// Shared widths and register map; all counters run free and wrap silently at their full width
package mem_stats_pkg;

   // Field widths
   localparam int ADDR_W       = 32;  // Memory byte address
   localparam int BTT_W        = 23;  // Mover bytes-to-transfer field
   localparam int DM_CMD_W     = 72;  // Full mover command word
   localparam int STS_W        = 8;   // Mover status byte
   localparam int COUNT_W      = 32;  // Event counters
   localparam int BYTE_COUNT_W = 48;  // Byte counters, long runs
   localparam int REG_ADDR_W   = 4;   // Sixteen register slots
   localparam int REG_DATA_W   = 64;  // Read data, counters zero-extended

   // Status byte decode
   localparam int STS_OKAY_BIT = 7;   // Set means transfer okay

   // Payload types
   typedef logic [ADDR_W-1:0]       addr_t;
   typedef logic [BTT_W-1:0]        btt_t;
   typedef logic [DM_CMD_W-1:0]     dm_cmd_t;  // Layout in dm_cmd_tracker
   typedef logic [STS_W-1:0]        sts_t;

   // Statistics types
   typedef logic [COUNT_W-1:0]      count_t;
   typedef logic [BYTE_COUNT_W-1:0] byte_count_t;

   // Register port types
   typedef logic [REG_ADDR_W-1:0]   reg_addr_t;
   typedef logic [REG_DATA_W-1:0]   reg_data_t;

   // Write direction counters
   localparam reg_addr_t REG_WR_CMD     = 4'd0;   // Accepted write commands
   localparam reg_addr_t REG_WR_STS     = 4'd1;   // Accepted write statuses
   localparam reg_addr_t REG_WR_STS_ERR = 4'd2;   // Write statuses with okay clear
   localparam reg_addr_t REG_WR_WORDS   = 4'd3;   // Write data beats
   localparam reg_addr_t REG_WR_PKTS    = 4'd4;   // Write beats with last
   localparam reg_addr_t REG_WR_BYTES   = 4'd5;   // Write bytes from keep

   // Read direction counters
   localparam reg_addr_t REG_RD_CMD     = 4'd6;   // Accepted read commands
   localparam reg_addr_t REG_RD_STS     = 4'd7;   // Accepted read statuses
   localparam reg_addr_t REG_RD_STS_ERR = 4'd8;   // Read statuses with okay clear
   localparam reg_addr_t REG_RD_WORDS   = 4'd9;   // Read data beats
   localparam reg_addr_t REG_RD_PKTS    = 4'd10;  // Read beats with last
   localparam reg_addr_t REG_RD_BYTES   = 4'd11;  // Read bytes from keep

   // Slots 12..15 are unmapped and read as zero

endpackage
